// File: hw/tlb_pkg.sv
// Shared sizes, types and state encodings for the set-associative TLB.
// Every TLB module imports this package in its body and uses scoped
// names for its ports.

package tlb_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================

    // One fixed page size, so only page numbers are ever handled
    localparam int VA_PAGE_BITS = 24;
    localparam int PA_PAGE_BITS = 20;

    localparam int NUM_SETS = 64;
    localparam int NUM_WAYS = 4;
    localparam int SET_IDX_BITS = 6;

    // The tag is whatever is left of the virtual page above the set index
    localparam int TAG_BITS = VA_PAGE_BITS - SET_IDX_BITS;

    // Accepted lookup to response, in clock edges
    localparam int LOOKUP_LATENCY = 4;

    // Idle cycles after each insert before another fill is taken
    localparam int FILL_BUBBLE_CYCLES = 8;

    // ======================================================================
    // Types
    // ======================================================================

    typedef logic [VA_PAGE_BITS-1:0] t_va_page;
    typedef logic [PA_PAGE_BITS-1:0] t_pa_page;
    typedef logic [SET_IDX_BITS-1:0] t_set_idx;
    typedef logic [TAG_BITS-1:0] t_tlb_tag;
    typedef logic [NUM_WAYS-1:0] t_way_vec;
    typedef logic [$clog2(NUM_WAYS)-1:0] t_way_idx;

    // A stored translation
    typedef struct packed {
        t_tlb_tag tag;
        t_pa_page pa;
    } t_tlb_entry;

    // Translation handed in by the page walker
    typedef struct packed {
        t_va_page va;
        t_pa_page pa;
    } t_fill_req;

    // Hit and miss are one-hot when a response is present
    typedef struct packed {
        logic hit;
        logic miss;
        t_pa_page pa;
        t_va_page miss_va;
    } t_lookup_rsp;

    // Write to the way store, one enable bit per way
    typedef struct packed {
        t_set_idx idx;
        t_tlb_entry entry;
        t_way_vec wen;
    } t_way_write;

    typedef enum logic [1:0] {
        IDLE,
        INSERT,
        BUBBLE
    } t_fill_state;

endpackage

// File: hw/tlb_way_store.sv
// Entry storage of the TLB, one memory and one valid array per way.
// Clears all valid bits with a walk over the sets after reset or an
// invalidation pulse, and returns a registered read one cycle after
// rd_idx is presented.

module tlb_way_store
(
    input  logic clk,
    input  logic reset,
    input  logic inval,
    input  tlb_pkg::t_way_write wr,
    input  tlb_pkg::t_set_idx rd_idx,
    output tlb_pkg::t_tlb_entry rd_entry [tlb_pkg::NUM_WAYS],
    output tlb_pkg::t_way_vec rd_valid,
    output logic store_ready
);
    import tlb_pkg::*;

    // ======================================================================
    // Clearing walk
    // ======================================================================

    // High while the walk visits the sets, one set per cycle
    logic walking;
    t_set_idx walk_idx;

    always_ff @(posedge clk)
    begin
        if (reset || inval)
        begin
            // A pulse arriving during a walk simply restarts it
            walking <= 1'b1;
            walk_idx <= '0;
        end
        else if (walking)
        begin
            walk_idx <= walk_idx + 1'b1;
            if (walk_idx == t_set_idx'(NUM_SETS - 1))
            begin
                walking <= 1'b0;
            end
        end
    end

    // Neither lookups nor fills are taken until every set is clean
    assign store_ready = ~walking;

    // ======================================================================
    // Per-way storage
    // ======================================================================

    // Each way is its own memory, so a fill writes one way and leaves
    // the others of the set untouched
    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : gen_way
        t_tlb_entry mem [NUM_SETS];
        logic [NUM_SETS-1:0] valid;

        // Entry memory with a registered read port
        always_ff @(posedge clk)
        begin
            // Writes are dropped during the walk, the entry would be stale
            if (!walking && wr.wen[w])
            begin
                mem[wr.idx] <= wr.entry;
            end
            rd_entry[w] <= mem[rd_idx];
        end

        // Valid bits, cleared one set at a time by the walk
        always_ff @(posedge clk)
        begin
            if (walking)
            begin
                valid[walk_idx] <= 1'b0;
            end
            else if (wr.wen[w])
            begin
                valid[wr.idx] <= 1'b1;
            end
            rd_valid[w] <= valid[rd_idx];
        end
    end

endmodule

// File: hw/tlb_lookup_pipe.sv
// Lookup pipeline of the TLB. Takes one lookup per cycle and answers
// each with a hit or a miss four edges after acceptance, in order.
// The stages are the storage read, tag XOR, XOR reduce and way select.
// lookup_en must already be qualified with the ready signal.

module tlb_lookup_pipe
(
    input  logic clk,
    input  logic reset,
    input  logic lookup_en,
    input  tlb_pkg::t_va_page lookup_va,
    output tlb_pkg::t_set_idx rd_idx,
    input  tlb_pkg::t_tlb_entry rd_entry [tlb_pkg::NUM_WAYS],
    input  tlb_pkg::t_way_vec rd_valid,
    output tlb_pkg::t_lookup_rsp lookup_rsp
);
    import tlb_pkg::*;

    // Stage valid bits and the virtual page carried alongside them
    logic s1_vld;
    logic s2_vld;
    logic s3_vld;
    t_va_page s1_va;
    t_va_page s2_va;
    t_va_page s3_va;

    // Stage 2 and 3 data
    t_tlb_tag s2_xor [NUM_WAYS];
    t_pa_page s2_pa [NUM_WAYS];
    t_pa_page s3_pa [NUM_WAYS];
    t_way_vec s3_match;

    // Way select, combinational from stage 3
    logic s3_any;
    t_way_idx s3_sel;

    // ======================================================================
    // Stage 1: storage read
    // ======================================================================

    // The set index is the low part of the virtual page
    assign rd_idx = lookup_va[SET_IDX_BITS-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
            s3_vld <= 1'b0;
        end
        else
        begin
            s1_vld <= lookup_en;
            s2_vld <= s1_vld;
            s3_vld <= s2_vld;
        end
        s1_va <= lookup_va;
        s2_va <= s1_va;
        s3_va <= s2_va;
    end

    // ======================================================================
    // Stage 2: tag XOR
    // ======================================================================

    // The full compare does not fit one cycle, so only the XOR is done here
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            // An invalid way gets an all ones pattern and can never match
            if (rd_valid[w])
            begin
                s2_xor[w] <= rd_entry[w].tag ^ s1_va[VA_PAGE_BITS-1 -: TAG_BITS];
            end
            else
            begin
                s2_xor[w] <= '1;
            end
            s2_pa[w] <= rd_entry[w].pa;
        end
    end

    // ======================================================================
    // Stage 3: reduce
    // ======================================================================

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            // A way matches when no XOR bit is set
            s3_match[w] <= ~(|s2_xor[w]);
        end
        s3_pa <= s2_pa;
    end

    // ======================================================================
    // Stage 4: way select and response
    // ======================================================================

    // Scanning downward leaves the lowest matching way selected
    always_comb
    begin
        s3_any = |s3_match;
        s3_sel = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (s3_match[w])
            begin
                s3_sel = t_way_idx'(w);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lookup_rsp.hit <= 1'b0;
            lookup_rsp.miss <= 1'b0;
        end
        else
        begin
            lookup_rsp.hit <= s3_vld & s3_any;
            lookup_rsp.miss <= s3_vld & ~s3_any;
        end
        lookup_rsp.pa <= s3_pa[s3_sel];
        // A miss hands back the page so the walker knows what to fetch
        lookup_rsp.miss_va <= s3_va;
    end

endmodule

// File: hw/tlb_fill_ctrl.sv
// Fill controller of the TLB. Takes one translation from the page
// walker, writes it into the way named by the round-robin victim
// pointer of its set, then waits out a fixed bubble before it takes
// the next fill.

module tlb_fill_ctrl
(
    input  logic clk,
    input  logic reset,
    input  logic fill_en,
    input  tlb_pkg::t_fill_req fill_req,
    input  logic store_ready,
    output logic fill_rdy,
    output tlb_pkg::t_way_write wr
);
    import tlb_pkg::*;

    t_fill_state state;
    logic [$clog2(FILL_BUBBLE_CYCLES)-1:0] bubble_cnt;

    // Captured fill, split into set index and stored entry
    t_set_idx fill_idx;
    t_tlb_entry fill_entry;

    // Next way to evict in each set
    t_way_idx victim [NUM_SETS];

    // ======================================================================
    // Fill state machine
    // ======================================================================

    // Ready only when idle and the storage is not being cleared
    assign fill_rdy = (state == IDLE) && store_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            bubble_cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (fill_en && fill_rdy)
                    begin
                        state <= INSERT;
                    end
                end

                // The write goes out during this single cycle
                INSERT:
                begin
                    state <= BUBBLE;
                    bubble_cnt <= '0;
                end

                BUBBLE:
                begin
                    bubble_cnt <= bubble_cnt + 1'b1;
                    if (bubble_cnt == ($bits(bubble_cnt))'(FILL_BUBBLE_CYCLES - 1))
                    begin
                        state <= IDLE;
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Tag is the high part of the page and the set index the low part
    always_ff @(posedge clk)
    begin
        if (fill_en && fill_rdy)
        begin
            fill_idx <= fill_req.va[SET_IDX_BITS-1:0];
            fill_entry.tag <= fill_req.va[VA_PAGE_BITS-1 -: TAG_BITS];
            fill_entry.pa <= fill_req.pa;
        end
    end

    // ======================================================================
    // Victim pointers
    // ======================================================================

    // The clearing walk of the store also restarts every set at way 0
    always_ff @(posedge clk)
    begin
        if (!store_ready)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                victim[s] <= '0;
            end
        end
        else if (state == INSERT)
        begin
            // Width of the pointer makes the increment wrap at NUM_WAYS
            victim[fill_idx] <= t_way_idx'(victim[fill_idx] + 1'b1);
        end
    end

    // Write request, one way enabled during INSERT only
    always_comb
    begin
        wr.idx = fill_idx;
        wr.entry = fill_entry;
        wr.wen = '0;
        if (state == INSERT)
        begin
            wr.wen = t_way_vec'(1) << victim[fill_idx];
        end
    end

endmodule

// File: hw/tlb_top.sv
// Top level of the set-associative TLB. Joins the way store, the
// lookup pipeline and the fill controller. Lookups and fills use
// valid/ready handshakes and a pulse on inval clears every entry.

module tlb_top
(
    input  logic clk,
    input  logic reset,
    input  logic lookup_en,
    input  logic inval,
    input  logic fill_en,
    input  tlb_pkg::t_va_page lookup_va,
    input  tlb_pkg::t_fill_req fill_req,
    output logic lookup_rdy,
    output logic fill_rdy,
    output tlb_pkg::t_lookup_rsp lookup_rsp
);
    import tlb_pkg::*;

    t_way_write wr;
    t_set_idx rd_idx;
    t_tlb_entry rd_entry [NUM_WAYS];
    t_way_vec rd_valid;
    logic store_ready;
    logic lookup_go;

    // Lookups wait for the end of the clearing walk
    assign lookup_rdy = store_ready;
    assign lookup_go = lookup_en & lookup_rdy;

    tlb_way_store way_store_inst (
        .clk         (clk),
        .reset       (reset),
        .inval       (inval),
        .wr          (wr),
        .rd_idx      (rd_idx),
        .rd_entry    (rd_entry),
        .rd_valid    (rd_valid),
        .store_ready (store_ready)
    );

    tlb_lookup_pipe lookup_pipe_inst (
        .clk        (clk),
        .reset      (reset),
        .lookup_en  (lookup_go),
        .lookup_va  (lookup_va),
        .rd_idx     (rd_idx),
        .rd_entry   (rd_entry),
        .rd_valid   (rd_valid),
        .lookup_rsp (lookup_rsp)
    );

    tlb_fill_ctrl fill_ctrl_inst (
        .clk         (clk),
        .reset       (reset),
        .fill_en     (fill_en),
        .fill_req    (fill_req),
        .store_ready (store_ready),
        .fill_rdy    (fill_rdy),
        .wr          (wr)
    );

endmodule

// File: bench/tb_clock_gen.sv
// Clock and reset source for the TLB testbench. clk has a 10 ns
// period and reset stays high for the first three rising edges.

module tb_clock_gen
(
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    // Reset is released on a falling edge like every other DUT input
    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: bench/tlb_sva.sv
// Handshake and timing assertions for the TLB, bound into tlb_top.
// Checks response exclusivity, response latency and the fill bubble.

module tlb_sva
(
    input logic clk,
    input logic reset,
    input logic lookup_en,
    input logic lookup_rdy,
    input logic fill_en,
    input logic fill_rdy,
    input tlb_pkg::t_lookup_rsp lookup_rsp
);
    timeunit 1ns;
    timeprecision 1ps;
    import tlb_pkg::*;

    // Count of assertion failures so far
    int fail_count = 0;

    // One bit per accepted lookup, shifted along with the pipeline
    logic [LOOKUP_LATENCY-1:0] accepted_sr;
    // Cycles since the last accepted fill, saturating at the bubble length
    logic [7:0] since_fill;
    logic lookup_acc;
    logic rsp_any;

    assign lookup_acc = lookup_en && lookup_rdy;
    assign rsp_any = lookup_rsp.hit || lookup_rsp.miss;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            accepted_sr <= '0;
            since_fill <= 8'(FILL_BUBBLE_CYCLES);
        end
        else
        begin
            accepted_sr <= {accepted_sr[LOOKUP_LATENCY-2:0], lookup_acc};
            if (fill_en && fill_rdy)
            begin
                since_fill <= '0;
            end
            else if (since_fill < 8'(FILL_BUBBLE_CYCLES))
            begin
                since_fill <= since_fill + 1'b1;
            end
        end
    end

    hit_miss_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(lookup_rsp.hit && lookup_rsp.miss))
    else
    begin
        $error("hit and miss are high in the same cycle");
        fail_count++;
    end

    // The oldest bit of the shift register lines up with the response
    rsp_after_latency: assert property (@(posedge clk) disable iff (reset)
        accepted_sr[LOOKUP_LATENCY-1] |-> rsp_any)
    else
    begin
        $error("an accepted lookup got no response after the pipeline latency");
        fail_count++;
    end

    rsp_has_request: assert property (@(posedge clk) disable iff (reset)
        rsp_any |-> accepted_sr[LOOKUP_LATENCY-1])
    else
    begin
        $error("a lookup response appeared without a matching request");
        fail_count++;
    end

    fill_bubble_held: assert property (@(posedge clk) disable iff (reset)
        fill_rdy |-> (since_fill >= 8'(FILL_BUBBLE_CYCLES)))
    else
    begin
        $error("fill_rdy rose before the fill bubble was over");
        fail_count++;
    end

endmodule

bind tlb_top tlb_sva tlb_sva_inst (
    .clk        (clk),
    .reset      (reset),
    .lookup_en  (lookup_en),
    .lookup_rdy (lookup_rdy),
    .fill_en    (fill_en),
    .fill_rdy   (fill_rdy),
    .lookup_rsp (lookup_rsp)
);

// File: bench/tb_top.sv
// Testbench for the TLB. Drives lookups, fills and invalidation on the
// falling edge and checks each response against a per-set FIFO model
// of round-robin replacement. Run it as the top module of the build.

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import tlb_pkg::*;

    logic clk;
    logic reset;
    logic lookup_en;
    logic inval;
    logic fill_en;
    t_va_page lookup_va;
    t_fill_req fill_req;
    logic lookup_rdy;
    logic fill_rdy;
    t_lookup_rsp lookup_rsp;

    // Reference model, per set the entries from oldest to newest
    t_tlb_tag model_tag [NUM_SETS][NUM_WAYS];
    t_pa_page model_pa [NUM_SETS][NUM_WAYS];
    int model_cnt [NUM_SETS];

    // Expected responses in issue order
    t_lookup_rsp exp_q [$];
    t_lookup_rsp exp_head;
    t_va_page filled_va [$];
    t_va_page evict_va [5];
    t_va_page new_va;
    t_set_idx evict_idx;
    logic [31:0] rng_state;
    string test_name;
    int error_count = 0;
    int test_err_base = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int sva_failures;

    tb_clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    tlb_top tlb_top_inst (
        .clk        (clk),
        .reset      (reset),
        .lookup_en  (lookup_en),
        .inval      (inval),
        .fill_en    (fill_en),
        .lookup_va  (lookup_va),
        .fill_req   (fill_req),
        .lookup_rdy (lookup_rdy),
        .fill_rdy   (fill_rdy),
        .lookup_rsp (lookup_rsp)
    );

    // ======================================================================
    // Random numbers and reference model
    // ======================================================================

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic void model_clear();
        for (int s = 0; s < NUM_SETS; s++)
        begin
            model_cnt[s] = 0;
        end
    endfunction

    // Set index is the low part of the page, the tag the high part
    function automatic t_lookup_rsp expected_rsp(t_va_page va);
        t_lookup_rsp r;
        t_set_idx idx;
        r = '0;
        idx = va[SET_IDX_BITS-1:0];
        for (int i = 0; i < model_cnt[idx]; i++)
        begin
            if (model_tag[idx][i] == va[VA_PAGE_BITS-1 -: TAG_BITS])
            begin
                r.hit = 1'b1;
                r.pa = model_pa[idx][i];
            end
        end
        r.miss = ~r.hit;
        r.miss_va = va;
        return r;
    endfunction

    function automatic void model_insert(t_va_page va, t_pa_page pa);
        t_set_idx idx;
        idx = va[SET_IDX_BITS-1:0];
        if (model_cnt[idx] == NUM_WAYS)
        begin
            // A full set drops its oldest entry
            for (int i = 1; i < NUM_WAYS; i++)
            begin
                model_tag[idx][i-1] = model_tag[idx][i];
                model_pa[idx][i-1] = model_pa[idx][i];
            end
            model_cnt[idx]--;
        end
        model_tag[idx][model_cnt[idx]] = va[VA_PAGE_BITS-1 -: TAG_BITS];
        model_pa[idx][model_cnt[idx]] = pa;
        model_cnt[idx]++;
    endfunction

    // A random page not held by the model, optionally forced into one set
    function automatic t_va_page fresh_page(logic fixed_set, t_set_idx idx);
        t_lookup_rsp r;
        t_va_page va;
        do
        begin
            va = t_va_page'(next_rand());
            if (fixed_set)
            begin
                va[SET_IDX_BITS-1:0] = idx;
            end
            r = expected_rsp(va);
        end while (r.hit);
        return va;
    endfunction

    function automatic string rsp_text(t_lookup_rsp r);
        return $sformatf("hit=%0b miss=%0b pa=%h miss_va=%h", r.hit, r.miss, r.pa, r.miss_va);
    endfunction

    // A hit is judged by its physical page and a miss by its virtual page
    function automatic logic rsp_matches(t_lookup_rsp e, t_lookup_rsp a);
        if (a.hit !== e.hit || a.miss !== e.miss)
        begin
            return 1'b0;
        end
        if (e.hit)
        begin
            return a.pa === e.pa;
        end
        return a.miss_va === e.miss_va;
    endfunction

    // ======================================================================
    // Stimulus tasks
    // ======================================================================

    task automatic issue_lookup(t_va_page va);
        while (!lookup_rdy)
        begin
            @(negedge clk);
        end
        lookup_en = 1'b1;
        lookup_va = va;
        exp_q.push_back(expected_rsp(va));
        @(negedge clk);
        lookup_en = 1'b0;
    endtask

    task automatic wait_fill_idle();
        while (!fill_rdy)
        begin
            @(negedge clk);
        end
    endtask

    task automatic do_fill(t_va_page va, t_pa_page pa);
        wait_fill_idle();
        fill_en = 1'b1;
        fill_req.va = va;
        fill_req.pa = pa;
        @(negedge clk);
        fill_en = 1'b0;
        model_insert(va, pa);
        filled_va.push_back(va);
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_err_base = error_count;
    endtask

    // Waits for every outstanding response, then reports the test
    task automatic end_test();
        while (exp_q.size() != 0)
        begin
            @(negedge clk);
        end
        tests_run++;
        if (error_count == test_err_base)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, error_count - test_err_base);
        end
    endtask

    // ======================================================================
    // Response checking and timeout
    // ======================================================================

    always @(negedge clk)
    begin
        if (!reset && (lookup_rsp.hit || lookup_rsp.miss))
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("Error in %s: a response arrived with no lookup outstanding",
                         test_name);
                error_count++;
            end
            if (exp_q.size() != 0)
            begin
                exp_head = exp_q.pop_front();
                assert (rsp_matches(exp_head, lookup_rsp))
                else
                begin
                    $display("** Error %s: expected %s, actual %s", test_name,
                             rsp_text(exp_head), rsp_text(lookup_rsp));
                    error_count++;
                end
            end
        end
    end

    // All tests together take well under a thousand cycles
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= 5000)
        begin
            $display("Timeout: the tests did not finish within 5000 cycles");
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        lookup_en = 1'b0;
        inval = 1'b0;
        fill_en = 1'b0;
        lookup_va = '0;
        fill_req = '0;
        rng_state = 32'hd1230334;
        model_clear();
        @(negedge clk);
        wait (!reset);
        @(negedge clk);

        // Empty TLB, every lookup misses
        start_test("reset_miss");
        assert (!lookup_rdy && !fill_rdy && !lookup_rsp.hit && !lookup_rsp.miss)
        else
        begin
            $display("Error in %s: a ready or response output was high after reset",
                     test_name);
            error_count++;
        end
        while (!lookup_rdy)
        begin
            @(negedge clk);
        end
        for (int i = 0; i < 16; i++)
        begin
            issue_lookup(t_va_page'(next_rand()));
        end
        end_test();

        start_test("fill_hit");
        for (int i = 0; i < 10; i++)
        begin
            do_fill(fresh_page(1'b0, '0), t_pa_page'(next_rand()));
        end
        wait_fill_idle();
        foreach (filled_va[i])
        begin
            issue_lookup(filled_va[i]);
        end
        end_test();

        // One lookup per cycle, alternating filled and random pages
        start_test("back_to_back");
        for (int i = 0; i < 32; i++)
        begin
            if (i % 2 == 0)
            begin
                issue_lookup(filled_va[next_rand() % filled_va.size()]);
            end
            else
            begin
                issue_lookup(t_va_page'(next_rand()));
            end
        end
        end_test();

        // Five tags in one set push the first one out
        start_test("set_evict");
        evict_idx = t_set_idx'(next_rand());
        for (int i = 0; i < 5; i++)
        begin
            evict_va[i] = fresh_page(1'b1, evict_idx);
            do_fill(evict_va[i], t_pa_page'(next_rand()));
        end
        wait_fill_idle();
        for (int i = 0; i < 5; i++)
        begin
            issue_lookup(evict_va[i]);
        end
        end_test();

        start_test("invalidate");
        wait_fill_idle();
        inval = 1'b1;
        @(negedge clk);
        inval = 1'b0;
        assert (!lookup_rdy)
        else
        begin
            $display("Error in %s: lookup_rdy stayed high after the inval pulse", test_name);
            error_count++;
        end
        while (!lookup_rdy)
        begin
            @(negedge clk);
        end
        model_clear();
        foreach (filled_va[i])
        begin
            issue_lookup(filled_va[i]);
        end
        new_va = fresh_page(1'b0, '0);
        do_fill(new_va, t_pa_page'(next_rand()));
        wait_fill_idle();
        issue_lookup(new_va);
        end_test();

        sva_failures = tlb_top_inst.tlb_sva_inst.fail_count;
        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, error_count, sva_failures);
        if (error_count == 0 && sva_failures == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sim.f
hw/tlb_pkg.sv
hw/tlb_way_store.sv
hw/tlb_lookup_pipe.sv
hw/tlb_fill_ctrl.sv
hw/tlb_top.sv
bench/tb_clock_gen.sv
bench/tlb_sva.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
# Builds the TLB testbench with Verilator, runs it and checks the result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_top -Mdir obj_dir -f sim.f

out=$(./obj_dir/Vtb_top +verilator+error+limit+100) || true
echo "$out"

if echo "$out" | grep -q "PASS: all tests"
then
    exit 0
fi
exit 1
